// File: src/cache_pkg.sv
package cache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths shared by cache, controller and memory
    ////////////////////////////////////////////////////////////////////////////

    parameter int ADDR_W = 8;     // 256 words of main memory
    parameter int DATA_W = 8;     // one byte per word

    ////////////////////////////////////////////////////////////////////////////
    // processor side request
    ////////////////////////////////////////////////////////////////////////////

    // taken when cpu_req is high and the cache is not busy
    typedef struct packed {
        logic              write;    // 1 = write, 0 = read
        logic [ADDR_W-1:0] addr;     // word address
        logic [DATA_W-1:0] data;     // write data ignored on reads
    } cache_req_t;

    ////////////////////////////////////////////////////////////////////////////
    // controller to main memory
    ////////////////////////////////////////////////////////////////////////////

    // rw high reads and rw low writes while ce is high
    typedef struct packed {
        logic              ce;       // chip enable held for the whole window
        logic              rw;       // 1 = read, 0 = write
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wr_data;
    } mem_bus_t;

    ////////////////////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        st_idle,         // waiting for a request strobe
        st_lookup,       // tag compare on the latched request
        st_mem_read,     // read window after a miss
        st_fill,         // write fetched word into the line
        st_mem_write,    // write-through window plus one bus recovery cycle
        st_finish        // done pulse with the result on the cpu port
    } ctrl_state_t;

endpackage

// File: src/main_memory.sv
`timescale 1ns/1ns

// register based RAM, one clock to answer
// the cache controller stretches each access to MEM_WAIT cycles
module main_memory
    import cache_pkg::*;
#(
    parameter int MEM_WORDS_LOG2 = ADDR_W    // 2**MEM_WORDS_LOG2 words
)
(
    input  logic              clk,
    input  logic              reset,         // sync clear of every word
    input  mem_bus_t          mem_bus,
    output logic [DATA_W-1:0] mem_rd_data    // registered read word
);

    localparam int MEM_WORDS = 2 ** MEM_WORDS_LOG2;

    logic [DATA_W-1:0]         mem_array [MEM_WORDS];
    logic [MEM_WORDS_LOG2-1:0] word_addr;

    // only the low address bits select a word
    assign word_addr = mem_bus.addr[MEM_WORDS_LOG2-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // read / write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // clear wins over any access in the same cycle
            mem_rd_data <= '0;
            for (int i = 0; i < MEM_WORDS; i++)
            begin
                mem_array[i] <= '0;
            end
        end
        else if (mem_bus.ce)                              // idle when ce low
        begin
            if (!mem_bus.rw)
            begin
                mem_array[word_addr] <= mem_bus.wr_data;  // write on rw low
            end
            else
            begin
                mem_rd_data <= mem_array[word_addr];      // read on rw high
            end
        end
    end

    // read word holds its value while ce is low or during writes
    // so the controller may sample it late in the window

endmodule

// File: src/cache_store.sv
`timescale 1ns/1ns

// direct mapped line storage, one word per line
// lookup is combinational, fill and update land on the clock edge
module cache_store
    import cache_pkg::*;
#(
    parameter int INDEX_W = 4
)
(
    input  logic                      clk,
    input  logic                      reset,

    // lookup port, async read
    input  logic [INDEX_W-1:0]        lookup_index,
    output logic [ADDR_W-INDEX_W-1:0] lookup_tag,
    output logic                      lookup_valid,
    output logic [DATA_W-1:0]         lookup_data,

    // line fill after a read miss
    input  logic                      fill_en,
    input  logic [INDEX_W-1:0]        fill_index,
    input  logic [ADDR_W-INDEX_W-1:0] fill_tag,
    input  logic [DATA_W-1:0]         fill_data,

    // data update on a write hit
    input  logic                      upd_en,
    input  logic [INDEX_W-1:0]        upd_index,
    input  logic [DATA_W-1:0]         upd_data
);

    localparam int TAG_W = ADDR_W - INDEX_W;
    localparam int LINES = 2 ** INDEX_W;

    logic [LINES-1:0]  valid_q;              // one bit per line
    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [DATA_W-1:0] data_mem [LINES];

    ////////////////////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= '0;                   // whole cache invalid
        end
        else if (fill_en)
        begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // tag and data arrays
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            tag_mem[fill_index]  <= fill_tag;
            data_mem[fill_index] <= fill_data;
        end
        else if (upd_en)
        begin
            data_mem[upd_index] <= upd_data;  // tag already matches
        end
    end

    // lookup, compare is done in the controller
    assign lookup_valid = valid_q[lookup_index];
    assign lookup_tag   = tag_mem[lookup_index];
    assign lookup_data  = data_mem[lookup_index];

endmodule

// File: src/cache_controller.sv
`timescale 1ns/1ns

// write-through, no write-allocate cache control
// read hit   done 1 cycle after accept
// read miss  lookup, MEM_WAIT read cycles, fill, finish
// write      lookup, MEM_WAIT write cycles + 1 recovery, finish
module cache_controller
    import cache_pkg::*;
#(
    parameter int INDEX_W  = 4,
    parameter int MEM_WAIT = 3              // at least 1
)
(
    input  logic                      clk,
    input  logic                      reset,

    // processor port
    input  logic                      cpu_req,
    input  cache_req_t                cpu_cmd,
    output logic                      cpu_busy,
    output logic                      cpu_done,
    output logic                      cpu_hit,
    output logic [DATA_W-1:0]         cpu_rd_data,

    // cache store
    output logic [INDEX_W-1:0]        lookup_index,
    input  logic [ADDR_W-INDEX_W-1:0] lookup_tag,
    input  logic                      lookup_valid,
    input  logic [DATA_W-1:0]         lookup_data,
    output logic                      fill_en,
    output logic [INDEX_W-1:0]        fill_index,
    output logic [ADDR_W-INDEX_W-1:0] fill_tag,
    output logic [DATA_W-1:0]         fill_data,
    output logic                      upd_en,
    output logic [INDEX_W-1:0]        upd_index,
    output logic [DATA_W-1:0]         upd_data,

    // main memory
    output mem_bus_t                  mem_bus,
    input  logic [DATA_W-1:0]         mem_rd_data
);

    localparam int TAG_W = ADDR_W - INDEX_W;
    localparam int CNT_W = $clog2(MEM_WAIT + 1);

    localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(MEM_WAIT - 1);  // last ce cycle
    localparam logic [CNT_W-1:0] WR_LAST = CNT_W'(MEM_WAIT);      // recovery cycle

    ctrl_state_t        state;
    ctrl_state_t        state_nxt;
    cache_req_t         req_q;              // latched request
    logic               hit_q;              // hit flag from lookup
    logic [CNT_W-1:0]   wait_cnt;           // cycles spent in a window
    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic               tag_hit;

    assign req_index = req_q.addr[INDEX_W-1:0];
    assign req_tag   = req_q.addr[ADDR_W-1:INDEX_W];
    assign tag_hit   = lookup_valid && (lookup_tag == req_tag);

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:      if (cpu_req) state_nxt = st_lookup;   // busy is low here
            st_lookup:
            begin
                if (req_q.write)
                    state_nxt = st_mem_write;   // writes always go to memory
                else if (tag_hit)
                    state_nxt = st_finish;
                else
                    state_nxt = st_mem_read;
            end
            st_mem_read:  if (wait_cnt == RD_LAST) state_nxt = st_fill;
            st_fill:      state_nxt = st_finish;
            st_mem_write: if (wait_cnt == WR_LAST) state_nxt = st_finish;
            st_finish:    state_nxt = st_idle;
            default:      state_nxt = st_idle;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // control registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= st_idle;
            wait_cnt <= '0;
            hit_q    <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            // counter runs only while a window state is held
            if ((state == st_mem_read || state == st_mem_write) && state_nxt == state)
                wait_cnt <= wait_cnt + 1'b1;
            else
                wait_cnt <= '0;
            if (state == st_lookup)
                hit_q <= tag_hit;               // kept until the next lookup
        end
    end

    // request and result words
    always_ff @(posedge clk)
    begin
        if (state == st_idle && cpu_req)
            req_q <= cpu_cmd;
        if (state == st_lookup)
            cpu_rd_data <= req_q.write ? req_q.data : lookup_data;
        else if (state == st_fill)
            cpu_rd_data <= mem_rd_data;         // miss result from memory
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    assign cpu_busy = (state != st_idle);
    assign cpu_done = (state == st_finish);
    assign cpu_hit  = hit_q;

    assign lookup_index = req_index;

    assign fill_en    = (state == st_fill);
    assign fill_index = req_index;
    assign fill_tag   = req_tag;
    assign fill_data  = mem_rd_data;           // valid after MEM_WAIT read cycles

    // line update lands with the last write cycle to memory
    assign upd_en    = (state == st_mem_write) && hit_q && (wait_cnt == RD_LAST);
    assign upd_index = req_index;
    assign upd_data  = req_q.data;

    always_comb
    begin
        mem_bus         = '0;
        mem_bus.rw      = 1'b1;                 // park in read
        mem_bus.addr    = req_q.addr;
        mem_bus.wr_data = req_q.data;
        case (state)
            st_mem_read:  mem_bus.ce = 1'b1;
            st_mem_write:
            begin
                mem_bus.ce = (wait_cnt < WR_LAST);  // low in recovery cycle
                mem_bus.rw = 1'b0;
            end
            default:      mem_bus.ce = 1'b0;
        endcase
    end

endmodule

// File: src/cache_top.sv
`timescale 1ns/1ns

// cache subsystem top, controller + line store + main memory
module cache_top
    import cache_pkg::*;
#(
    parameter int INDEX_W  = 4,    // 16 lines
    parameter int MEM_WAIT = 3     // cycles per memory access
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              cpu_req,       // one cycle strobe
    input  cache_req_t        cpu_cmd,
    output logic              cpu_busy,
    output logic              cpu_done,      // one cycle pulse
    output logic              cpu_hit,       // valid with cpu_done
    output logic [DATA_W-1:0] cpu_rd_data    // valid with cpu_done
);

    localparam int TAG_W = ADDR_W - INDEX_W;

    ////////////////////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////////////////////

    logic [INDEX_W-1:0] lookup_index;
    logic [TAG_W-1:0]   lookup_tag;
    logic               lookup_valid;
    logic [DATA_W-1:0]  lookup_data;
    logic               fill_en;
    logic [INDEX_W-1:0] fill_index;
    logic [TAG_W-1:0]   fill_tag;
    logic [DATA_W-1:0]  fill_data;
    logic               upd_en;
    logic [INDEX_W-1:0] upd_index;
    logic [DATA_W-1:0]  upd_data;
    mem_bus_t           mem_bus;
    logic [DATA_W-1:0]  mem_rd_data;

    cache_controller #(
        .INDEX_W  (INDEX_W),
        .MEM_WAIT (MEM_WAIT)
    ) u_ctrl (.*);

    cache_store #(
        .INDEX_W (INDEX_W)
    ) u_store (.*);

    // full address range backs the cache
    main_memory #(
        .MEM_WORDS_LOG2 (ADDR_W)
    ) u_mem (
        .clk         (clk),
        .reset       (reset),
        .mem_bus     (mem_bus),
        .mem_rd_data (mem_rd_data)
    );

endmodule

// File: bench/cache_model.svh
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// reference model of memory words and line tags
////////////////////////////////////////////////////////////////////////////

logic [DATA_W-1:0] model_mem [256];      // zero after reset
bit                model_valid [LINES];
logic [TAG_W-1:0]  model_tag [LINES];

function automatic void clear_model();
    for (int i = 0; i < 256; i++)
        model_mem[i] = '0;
    for (int i = 0; i < LINES; i++)
    begin
        model_valid[i] = 1'b0;
        model_tag[i]   = '0;
    end
endfunction

// line holds this address
function automatic bit model_hit(input logic [ADDR_W-1:0] addr);
    logic [INDEX_W-1:0] idx;
    idx = addr[INDEX_W-1:0];
    return model_valid[idx] && (model_tag[idx] == addr[ADDR_W-1:INDEX_W]);
endfunction

// writes go through to memory and never allocate, reads allocate
function automatic void model_update(input cache_req_t cmd);
    if (cmd.write)
        model_mem[cmd.addr] = cmd.data;
    else
    begin
        model_valid[cmd.addr[INDEX_W-1:0]] = 1'b1;
        model_tag[cmd.addr[INDEX_W-1:0]]   = cmd.addr[ADDR_W-1:INDEX_W];
    end
endfunction

////////////////////////////////////////////////////////////////////////////
// drives one request on the cpu port from a falling edge
////////////////////////////////////////////////////////////////////////////

task automatic send_request(input cache_req_t cmd, input bit stray,
                            output logic [DATA_W-1:0] rd_data, output bit hit,
                            output int cycles);
    cache_req_t stray_cmd;
    int         guard;
    stray_cmd.write = 1'b1;                  // would corrupt memory if taken
    stray_cmd.addr  = cmd.addr;
    stray_cmd.data  = ~cmd.data;
    guard = 0;
    while (cpu_busy)                         // previous access still closing
    begin
        @(negedge clk);
        guard++;
        if (guard > TIMEOUT)
            abort_run("cache stayed busy before a new request");
    end
    cpu_cmd = cmd;
    cpu_req = 1'b1;
    @(negedge clk);                          // accepting edge lies in between
    cpu_req = 1'b0;
    cycles  = 0;
    while (!cpu_done)
    begin
        assert (cpu_busy) else flag_failure("cpu_busy low inside an access window");
        if (stray && cycles == 0)
        begin
            cpu_cmd = stray_cmd;             // strobe while busy
            cpu_req = 1'b1;
        end
        else
            cpu_req = 1'b0;
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT)
            abort_run("no cpu_done within the timeout");
    end
    cpu_req = 1'b0;
    assert (cpu_busy) else flag_failure("cpu_busy low in the done cycle");
    rd_data = cpu_rd_data;
    hit     = cpu_hit;
endtask

`endif

// File: bench/cache_tb.sv
`timescale 1ns/1ns

module cache_tb
    import cache_pkg::*;
;

    localparam int INDEX_W  = 4;
    localparam int MEM_WAIT = 3;
    localparam int TAG_W    = ADDR_W - INDEX_W;
    localparam int LINES    = 2 ** INDEX_W;
    localparam int TIMEOUT  = 40;             // cycles per wait loop

    logic              clk;
    logic              reset;
    logic              cpu_req;
    cache_req_t        cpu_cmd;
    logic              cpu_busy;
    logic              cpu_done;
    logic              cpu_hit;
    logic [DATA_W-1:0] cpu_rd_data;

    int checks;
    int errors;
    int test_checks;                          // counts at the start of a test
    int test_errors;
    int issued;                               // accepted requests
    int done_seen;                            // cpu_done pulses
    int seed;

    cache_top #(
        .INDEX_W  (INDEX_W),
        .MEM_WAIT (MEM_WAIT)
    ) u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                // 4 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare(input string name, input int got, input int exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic flag_failure(input string what);
        errors++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Checks failed");
        $finish;
    endtask

    task automatic report_test(input string name);
        $display("test %-24s %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    `include "cache_model.svh"

    // one access checked against the model including latency
    task automatic check_access(input bit wr, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data, input bit stray);
        cache_req_t        cmd;
        logic [DATA_W-1:0] exp_data;
        logic [DATA_W-1:0] got_data;
        bit                exp_hit;
        bit                got_hit;
        int                exp_cycles;
        int                got_cycles;
        cmd.write  = wr;
        cmd.addr   = addr;
        cmd.data   = data;
        exp_hit    = model_hit(addr);
        exp_data   = wr ? data : model_mem[addr];  // write echoes its own word
        exp_cycles = (exp_hit && !wr) ? 1 : MEM_WAIT + 2;
        send_request(cmd, stray, got_data, got_hit, got_cycles);
        compare("cpu_rd_data", int'(got_data), int'(exp_data));
        compare("cpu_hit", int'(got_hit), int'(exp_hit));
        compare("done latency", got_cycles, exp_cycles);
        model_update(cmd);
        issued++;
    endtask

    // the done just seen is counted on the rising edge in between
    task automatic check_done_count();
        @(negedge clk);
        compare("cpu_done count", done_seen, issued);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // protocol watch
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (!reset && cpu_done)
            done_seen++;                      // pre-edge value
    end

    // busy from the cycle after an accepted strobe
    accept_to_busy: assert property (@(posedge clk) disable iff (reset)
                                     cpu_req && !cpu_busy |=> cpu_busy)
        else flag_failure("request strobe while idle did not raise cpu_busy");

    done_inside_busy: assert property (@(posedge clk) disable iff (reset)
                                       cpu_done |-> cpu_busy)
        else flag_failure("cpu_done without cpu_busy");

    // done is a single cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
                                     cpu_done |=> !cpu_done)
        else flag_failure("cpu_done longer than a cycle");

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] rnd;
        reset     = 1'b1;
        cpu_req   = 1'b0;
        cpu_cmd   = '0;
        checks    = 0;
        errors    = 0;
        issued    = 0;
        done_seen = 0;
        seed      = 19;
        test_checks = 0;
        test_errors = 0;
        clear_model();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // empty cache over zeroed memory
        compare("cpu_busy", int'(cpu_busy), 0);
        compare("cpu_done", int'(cpu_done), 0);
        check_access(1'b0, 8'h35, 8'h00, 1'b0);     // miss
        check_access(1'b0, 8'h35, 8'h00, 1'b0);     // hit
        report_test("after reset");

        check_access(1'b1, 8'h35, 8'h5a, 1'b0);     // write hit
        check_access(1'b0, 8'h35, 8'h00, 1'b0);
        check_access(1'b1, 8'h72, 8'he1, 1'b0);     // write miss without allocate
        check_access(1'b0, 8'h72, 8'h00, 1'b0);
        check_access(1'b0, 8'h72, 8'h00, 1'b0);
        report_test("write then read");

        // 0x46 and 0x96 share index 6
        check_access(1'b0, 8'h46, 8'h00, 1'b0);
        check_access(1'b1, 8'h46, 8'hc3, 1'b0);
        check_access(1'b0, 8'h96, 8'h00, 1'b0);     // evicts 0x46
        check_access(1'b0, 8'h46, 8'h00, 1'b0);     // refetch from memory
        report_test("eviction");

        check_access(1'b0, 8'ha7, 8'h00, 1'b0);     // read miss
        check_access(1'b0, 8'ha7, 8'h00, 1'b0);     // read hit
        check_access(1'b1, 8'ha7, 8'h3c, 1'b0);     // write hit
        check_access(1'b1, 8'hb8, 8'h11, 1'b0);     // write miss
        report_test("latency");

        check_access(1'b0, 8'h35, 8'h00, 1'b1);     // stray in a 1 cycle window
        check_access(1'b1, 8'h21, 8'h99, 1'b1);     // stray in a write window
        check_access(1'b0, 8'h35, 8'h00, 1'b0);
        check_access(1'b0, 8'h21, 8'h00, 1'b0);
        check_done_count();
        report_test("busy strobe ignored");

        for (int n = 0; n < 200; n++)
        begin
            rnd = $random(seed);
            // 64 addresses with four tags per line
            check_access(rnd[0], {2'b00, rnd[13:8]}, rnd[23:16], 1'b0);
        end
        check_done_count();
        report_test("random sequence");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
src/cache_pkg.sv
src/main_memory.sv
src/cache_store.sv
src/cache_controller.sv
src/cache_top.sv
bench/cache_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = cache_tb
FILE_LIST  = files.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only -Wall --timing --assert
SIM_FLAGS  = --binary -j 0 --timing --assert -Wno-fatal
PASS_MSG   = All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

build:
	$(TOOL) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from the pass line in the simulator output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
